// File: common/sched_pkg.sv
/*
 * Issue scheduler package
 * Entry count, operand tags, dispatch and issue payloads, entry states
 */
`default_nettype none

package sched_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int NUM_ENTRIES  = 4;
  localparam int NUM_OPERANDS = 2;

  // --------------------
  // Scalar types
  // --------------------
  typedef logic [4:0] rnid_t;        // Physical register tag
  typedef logic [3:0] br_mask_t;     // One bit per outstanding branch
  typedef logic [1:0] brtag_t;
  typedef logic [7:0] inst_tag_t;
  typedef logic [1:0] entry_idx_t;
  typedef logic [NUM_ENTRIES-1:0] entry_vec_t;

  // One renamed source operand
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
    logic  ready;
    logic  predict_ready;            // Woken by a load that may still miss
  } src_t;

  // Written by dispatch on a put
  typedef struct packed {
    inst_tag_t                   inst_tag;
    br_mask_t                    br_mask;
    src_t [NUM_OPERANDS-1:0]     srcs;
  } disp_t;

  // Presented on the ALU issue port
  typedef struct packed {
    logic                        valid;
    inst_tag_t                   inst_tag;
    br_mask_t                    br_mask;
    src_t [NUM_OPERANDS-1:0]     srcs;
  } issue_t;

  // Entry life cycle
  typedef enum logic [1:0] {
    INIT,
    WAIT,
    ISSUED,
    SCHED_CLEAR
  } sched_state_t;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
/*
 * Execution side buses
 * Early wake-up, write-back, load miss and branch update
 */
`default_nettype none

package bus_pkg;

  localparam int EARLY_WR_NUM = 2;
  localparam int PHY_WR_NUM   = 2;
  localparam int MISPRED_NUM  = 1;

  // Early wake-up, possibly from a load that can still miss
  typedef struct packed {
    logic             valid;
    sched_pkg::rnid_t rnid;
    logic             may_mispred;
  } early_wr_t;

  // Physical register write-back
  typedef struct packed {
    logic             valid;
    sched_pkg::rnid_t rnid;
  } phy_wr_t;

  // Load miss on a previously announced tag
  typedef struct packed {
    logic             valid;
    sched_pkg::rnid_t rnid;
  } mispred_t;

  typedef struct packed {
    logic              update;
    sched_pkg::brtag_t brtag;
    logic              mispredict;   // Kill dependents of brtag
  } br_upd_t;

endpackage

`default_nettype wire

// File: issue/issue_entry.sv
/*
 * Issue entry
 * Holds one op, wakes its sources from the buses, replays after a
 * load miss and dies on a mispredicted branch
 */
`default_nettype none

module issue_entry (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_put,
  input  sched_pkg::disp_t    i_put_data,
  input  bus_pkg::early_wr_t  i_early_wr [bus_pkg::EARLY_WR_NUM],
  input  bus_pkg::phy_wr_t    i_phy_wr   [bus_pkg::PHY_WR_NUM],
  input  bus_pkg::mispred_t   i_mispred  [bus_pkg::MISPRED_NUM],
  input  bus_pkg::br_upd_t    i_br_upd,
  input  logic                i_entry_picked,
  output logic                o_entry_valid,
  output logic                o_entry_ready,
  output sched_pkg::issue_t   o_entry
);
  import sched_pkg::*;
  import bus_pkg::*;

  sched_state_t            r_state;
  sched_state_t            w_state_next;
  issue_t                  r_entry;
  issue_t                  w_woken;
  issue_t                  w_init_entry;
  issue_t                  w_entry_next;

  rnid_t                   w_rs_rnid [NUM_OPERANDS];
  logic [NUM_OPERANDS-1:0] w_rs_valid;
  logic [NUM_OPERANDS-1:0] w_rs_rel_hit;
  logic [NUM_OPERANDS-1:0] w_rs_may_mispred;
  logic [NUM_OPERANDS-1:0] w_rs_phy_hit;
  logic [NUM_OPERANDS-1:0] w_rs_mispred;
  logic [NUM_OPERANDS-1:0] w_rs_pred;
  logic                    w_pred_mispred;
  logic                    w_valid;
  logic                    w_br_flush;
  logic                    w_put_flush;

  function automatic logic all_ready(issue_t e);
    logic ret;
    ret = 1'b1;
    for (int i = 0; i < NUM_OPERANDS; i++) begin
      ret = ret & (!e.srcs[i].valid | e.srcs[i].ready | e.srcs[i].predict_ready);
    end
    return ret;
  endfunction

  // --------------------
  // Tag match
  // --------------------
  always_comb begin
    for (int s = 0; s < NUM_OPERANDS; s++) begin
      // Put data is matched in its own cycle
      w_rs_rnid[s]        = i_put ? i_put_data.srcs[s].rnid  : r_entry.srcs[s].rnid;
      w_rs_valid[s]       = i_put ? i_put_data.srcs[s].valid : r_entry.srcs[s].valid;
      w_rs_rel_hit[s]     = 1'b0;
      w_rs_may_mispred[s] = 1'b0;
      w_rs_phy_hit[s]     = 1'b0;
      w_rs_mispred[s]     = 1'b0;
      w_rs_pred[s]        = r_entry.srcs[s].predict_ready;
      for (int p = 0; p < EARLY_WR_NUM; p++) begin
        if (i_early_wr[p].valid && (i_early_wr[p].rnid == w_rs_rnid[s])) begin
          w_rs_rel_hit[s]     = w_rs_valid[s];
          w_rs_may_mispred[s] = i_early_wr[p].may_mispred;
        end
      end
      for (int p = 0; p < PHY_WR_NUM; p++) begin
        if (i_phy_wr[p].valid && (i_phy_wr[p].rnid == w_rs_rnid[s])) begin
          w_rs_phy_hit[s] = w_rs_valid[s];
        end
      end
      for (int p = 0; p < MISPRED_NUM; p++) begin
        if (i_mispred[p].valid && (i_mispred[p].rnid == w_rs_rnid[s])) begin
          w_rs_mispred[s] = w_rs_valid[s];
        end
      end
    end
  end

  assign w_pred_mispred = |(w_rs_pred & w_rs_mispred);
  assign w_valid        = (r_state != INIT);

  assign w_br_flush  = w_valid & i_br_upd.update & i_br_upd.mispredict &
                       r_entry.br_mask[i_br_upd.brtag];
  assign w_put_flush = i_put & i_br_upd.update & i_br_upd.mispredict &
                       i_put_data.br_mask[i_br_upd.brtag];

  // Stored entry with this cycle's wake-ups applied
  always_comb begin
    w_woken       = r_entry;
    w_woken.valid = w_valid;
    for (int s = 0; s < NUM_OPERANDS; s++) begin
      w_woken.srcs[s].ready = r_entry.srcs[s].ready | w_rs_phy_hit[s] |
                              (w_rs_rel_hit[s] & ~w_rs_may_mispred[s]);
      w_woken.srcs[s].predict_ready = w_rs_rel_hit[s] & w_rs_may_mispred[s];
    end
    if (i_br_upd.update) begin
      w_woken.br_mask[i_br_upd.brtag] = 1'b0;
    end
  end

  // Fresh entry from dispatch, woken the same way
  always_comb begin
    w_init_entry.valid    = 1'b1;
    w_init_entry.inst_tag = i_put_data.inst_tag;
    w_init_entry.br_mask  = i_put_data.br_mask;
    for (int s = 0; s < NUM_OPERANDS; s++) begin
      w_init_entry.srcs[s].valid = i_put_data.srcs[s].valid;
      w_init_entry.srcs[s].rnid  = i_put_data.srcs[s].rnid;
      w_init_entry.srcs[s].ready = i_put_data.srcs[s].ready | w_rs_phy_hit[s] |
                                   (w_rs_rel_hit[s] & ~w_rs_may_mispred[s]);
      w_init_entry.srcs[s].predict_ready = w_rs_rel_hit[s] & w_rs_may_mispred[s];
    end
    if (i_br_upd.update) begin
      w_init_entry.br_mask[i_br_upd.brtag] = 1'b0;
    end
  end

  // --------------------
  // Entry FSM
  // --------------------
  always_comb begin
    w_state_next = r_state;
    w_entry_next = w_woken;
    case (r_state)
      INIT: begin
        if (i_put) begin
          w_entry_next = w_init_entry;
          w_state_next = w_put_flush ? SCHED_CLEAR : WAIT;   // Killed on arrival
        end
      end
      WAIT: begin
        if (w_br_flush) begin
          w_state_next = SCHED_CLEAR;
        end else if (o_entry_ready && i_entry_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_br_flush) begin
          w_state_next = SCHED_CLEAR;
        end else if (w_pred_mispred) begin
          // Load missed, wait for the real write-back
          w_state_next = WAIT;
          for (int s = 0; s < NUM_OPERANDS; s++) begin
            w_entry_next.srcs[s].predict_ready = 1'b0;
          end
        end else begin
          w_state_next = SCHED_CLEAR;
        end
      end
      SCHED_CLEAR: begin
        w_state_next = INIT;
      end
      default: w_state_next = INIT;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_entry <= w_entry_next;
  end

  assign o_entry_valid = w_valid;
  assign o_entry_ready = (r_state == WAIT) & ~w_br_flush & all_ready(w_woken);
  assign o_entry       = w_woken;

endmodule

`default_nettype wire

// File: issue/issue_picker.sv
/*
 * Issue picker
 * Fixed priority grant of the ALU port, lowest ready entry wins
 */
`default_nettype none

module issue_picker (
  input  sched_pkg::entry_vec_t i_entry_ready,
  input  sched_pkg::issue_t     i_entries [sched_pkg::NUM_ENTRIES],
  output sched_pkg::entry_vec_t o_picked,
  output logic                  o_issue_valid,
  output sched_pkg::issue_t     o_issue
);
  import sched_pkg::*;

  // Isolate lowest set bit
  assign o_picked      = i_entry_ready & (~i_entry_ready + entry_vec_t'(1));
  assign o_issue_valid = |i_entry_ready;

  // One-hot mux onto the issue port
  always_comb begin
    o_issue = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (o_picked[i]) begin
        o_issue = i_entries[i];
      end
    end
    o_issue.valid = o_issue_valid;
  end

endmodule

`default_nettype wire

// File: issue/issue_alloc.sv
/*
 * Entry allocator
 * Steers a dispatch put to the lowest free entry, flags full
 */
`default_nettype none

module issue_alloc (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_put,
  input  sched_pkg::entry_vec_t i_entry_valid,
  output sched_pkg::entry_vec_t o_entry_put,
  output logic                  o_full
);
  import sched_pkg::*;

  entry_vec_t r_claim;      // Entries written last cycle
  entry_vec_t w_free;
  entry_vec_t w_first_free;

  assign w_free       = ~(i_entry_valid | r_claim);
  assign w_first_free = w_free & (~w_free + entry_vec_t'(1));

  assign o_entry_put = i_put ? w_first_free : '0;
  assign o_full      = ~|w_free;

  // Hold the claim until the entry reports valid
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_claim <= '0;
    end else begin
      r_claim <= o_entry_put;
    end
  end

endmodule

`default_nettype wire

// File: design/issue_sched_top.sv
/*
 * Issue scheduler top
 * Allocator, four entries and the ALU port picker
 */
`default_nettype none

module issue_sched_top (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // Dispatch
  input  logic                i_put,
  input  sched_pkg::disp_t    i_put_data,
  output logic                o_full,
  // Execution side buses
  input  bus_pkg::early_wr_t  i_early_wr [bus_pkg::EARLY_WR_NUM],
  input  bus_pkg::phy_wr_t    i_phy_wr   [bus_pkg::PHY_WR_NUM],
  input  bus_pkg::mispred_t   i_mispred  [bus_pkg::MISPRED_NUM],
  input  bus_pkg::br_upd_t    i_br_upd,
  // ALU issue port
  output logic                o_issue_valid,
  output sched_pkg::issue_t   o_issue
);
  import sched_pkg::*;

  entry_vec_t w_entry_put;
  entry_vec_t w_entry_valid;
  entry_vec_t w_entry_ready;
  entry_vec_t w_picked;
  issue_t     w_entries [NUM_ENTRIES];

  issue_alloc u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_put         (i_put),
    .i_entry_valid (w_entry_valid),
    .o_entry_put   (w_entry_put),
    .o_full        (o_full)
  );

  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    issue_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_entry_put[e]),
      .i_put_data     (i_put_data),
      .i_early_wr     (i_early_wr),
      .i_phy_wr       (i_phy_wr),
      .i_mispred      (i_mispred),
      .i_br_upd       (i_br_upd),
      .i_entry_picked (w_picked[e]),
      .o_entry_valid  (w_entry_valid[e]),
      .o_entry_ready  (w_entry_ready[e]),
      .o_entry        (w_entries[e])
    );
  end

  issue_picker u_picker (
    .i_entry_ready (w_entry_ready),
    .i_entries     (w_entries),
    .o_picked      (w_picked),
    .o_issue_valid (o_issue_valid),
    .o_issue       (o_issue)
  );

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
/*
 * Testbench clock and reset
 */
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS = 20;  // 40 ns period

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #2 o_reset_n = 1'b1;
  end

  always #HALF_NS o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: dv/issue_sched_checker.sv
/*
 * Issue scheduler checker
 * Concurrent rules on the dispatch and ALU issue ports
 */
`default_nettype none

module issue_sched_checker (
  input wire logic              i_clk,
  input wire logic              i_reset_n,
  input wire logic              i_put,
  input wire logic              o_full,
  input wire bus_pkg::br_upd_t  i_br_upd,
  input wire logic              o_issue_valid,
  input wire sched_pkg::issue_t o_issue
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;   // Failed assertions so far

  // Dispatch never writes into a full scheduler
  a_put_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_put |-> !o_full)
    else begin
      $error("put while o_full high");
      fail_cnt++;
    end

  // A granted entry leaves WAIT, so no tag repeats on the next cycle
  a_no_repeat: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_issue_valid |=> !(o_issue_valid && o_issue.inst_tag == $past(o_issue.inst_tag)))
    else begin
      $error("same inst_tag issued on consecutive cycles");
      fail_cnt++;
    end

  // Every valid source is woken at issue
  a_srcs_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_issue_valid |->
      (!o_issue.srcs[0].valid || o_issue.srcs[0].ready || o_issue.srcs[0].predict_ready) &&
      (!o_issue.srcs[1].valid || o_issue.srcs[1].ready || o_issue.srcs[1].predict_ready))
    else begin
      $error("issue with a source not ready");
      fail_cnt++;
    end

  // Resolved branch bit is gone from later issues
  a_mask_cleared: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_br_upd.update |=> !(o_issue_valid && o_issue.br_mask[$past(i_br_upd.brtag)]))
    else begin
      $error("issued op still carries a resolved branch bit");
      fail_cnt++;
    end

  // Idle right after reset
  a_reset_idle: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> (!o_issue_valid && !o_full))
    else begin
      $error("scheduler not idle after reset");
      fail_cnt++;
    end

endmodule

bind issue_sched_top issue_sched_checker u_checker (.*);

`default_nettype wire

// File: dv/issue_sched_tb.sv
/*
 * Issue scheduler testbench
 * Directed tests with random tags, issue bookkeeping and a watchdog
 */
`default_nettype none

module issue_sched_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import sched_pkg::*;
  import bus_pkg::*;

  localparam int CLK_NS    = 40;
  localparam int TEST_LEN  = 150;              // Cycles per test, upper bound
  localparam int TOTAL_LEN = 5 * TEST_LEN;

  logic      clk;
  logic      reset_n;
  logic      put;
  disp_t     put_data;
  logic      full;
  early_wr_t early_wr [EARLY_WR_NUM];
  phy_wr_t   phy_wr   [PHY_WR_NUM];
  mispred_t  mispred  [MISPRED_NUM];
  br_upd_t   br_upd;
  logic      issue_valid;
  issue_t    issue;

  int          allowed   [256];                // Issues permitted per inst_tag
  int          issue_cnt [256];
  br_mask_t    mask_of   [256];
  inst_tag_t   test_tags [$];
  logic [31:0] rnid_ready;                     // Woken for real
  logic [31:0] spec_now;                       // Speculative wake this cycle
  logic [31:0] used_rn;
  inst_tag_t   next_tag;
  int          errors;
  int          err_start;
  int          tests_run;
  int          tests_bad;

  tb_clkgen u_clkgen (.o_clk(clk), .o_reset_n(reset_n));

  issue_sched_top i_dut (
    .i_clk(clk), .i_reset_n(reset_n), .i_put(put), .i_put_data(put_data), .o_full(full),
    .i_early_wr(early_wr), .i_phy_wr(phy_wr), .i_mispred(mispred), .i_br_upd(br_upd),
    .o_issue_valid(issue_valid), .o_issue(issue)
  );

  // --------------------
  // Bus drive
  // --------------------
  task automatic clear_bus();
    put    = 1'b0;
    br_upd = '0;
    for (int p = 0; p < EARLY_WR_NUM; p++) early_wr[p] = '0;
    for (int p = 0; p < PHY_WR_NUM; p++) phy_wr[p] = '0;
    for (int p = 0; p < MISPRED_NUM; p++) mispred[p] = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    clear_bus();
    spec_now = '0;
  endtask

  function automatic rnid_t new_rnid();
    rnid_t r;
    r = rnid_t'($urandom_range(31, 1));
    while (used_rn[r]) r = rnid_t'($urandom_range(31, 1));
    used_rn[r] = 1'b1;
    return r;
  endfunction

  function automatic inst_tag_t alloc_tag();
    inst_tag_t t;
    t = next_tag;
    next_tag++;
    test_tags.push_back(t);
    allowed[t]   = 1;
    issue_cnt[t] = 0;
    return t;
  endfunction

  task automatic drive_put(input inst_tag_t tag, input br_mask_t mask,
                           input logic v0, input rnid_t r0, input logic v1, input rnid_t r1);
    while (full) next_cycle();
    put                   = 1'b1;
    put_data              = '0;
    put_data.inst_tag     = tag;
    put_data.br_mask      = mask;
    put_data.srcs[0].valid = v0;
    put_data.srcs[0].rnid  = r0;
    put_data.srcs[1].valid = v1;
    put_data.srcs[1].rnid  = r1;
    mask_of[tag]          = mask;
  endtask

  task automatic drive_phy(input rnid_t rn, input int port);
    phy_wr[port]   = '{valid: 1'b1, rnid: rn};
    rnid_ready[rn] = 1'b1;
  endtask

  task automatic drive_early(input rnid_t rn, input logic spec);
    early_wr[0] = '{valid: 1'b1, rnid: rn, may_mispred: spec};
    if (spec) spec_now[rn] = 1'b1;
    else rnid_ready[rn] = 1'b1;
  endtask

  task automatic drive_mispred(input rnid_t rn);
    mispred[0]     = '{valid: 1'b1, rnid: rn};
    rnid_ready[rn] = 1'b0;
  endtask

  // Kills pending dependents, clears the bit everywhere
  task automatic drive_br(input brtag_t b, input logic mp);
    br_upd = '{update: 1'b1, brtag: b, mispredict: mp};
    foreach (test_tags[i]) begin
      if (mp && mask_of[test_tags[i]][b] && issue_cnt[test_tags[i]] == 0)
        allowed[test_tags[i]] = 0;
      mask_of[test_tags[i]][b] = 1'b0;
    end
  endtask

  // --------------------
  // Issue monitor
  // --------------------
  always @(negedge clk) begin
    if (reset_n && issue_valid) begin
      issue_cnt[issue.inst_tag]++;
      assert (issue_cnt[issue.inst_tag] <= allowed[issue.inst_tag]) else begin
        $display("** Error: issue_cnt[0x%h] = 0x%h, expected at most 0x%h",
                 issue.inst_tag, issue_cnt[issue.inst_tag], allowed[issue.inst_tag]);
        errors++;
      end
      for (int s = 0; s < NUM_OPERANDS; s++) begin
        assert (!issue.srcs[s].valid || rnid_ready[issue.srcs[s].rnid] ||
                spec_now[issue.srcs[s].rnid]) else begin
          $display("op 0x%h issued before source 0x%h was woken",
                   issue.inst_tag, issue.srcs[s].rnid);
          errors++;
        end
      end
    end
  end

  // --------------------
  // Test framing
  // --------------------
  // Own checks plus failed checker assertions
  function automatic int error_count();
    return errors + i_dut.u_checker.fail_cnt;
  endfunction

  function automatic logic all_done();
    foreach (test_tags[i]) begin
      if (issue_cnt[test_tags[i]] < allowed[test_tags[i]]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic begin_test();
    test_tags.delete();
    used_rn    = '0;
    rnid_ready = '0;
    err_start  = error_count();
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (!all_done() && n < 100) begin
      next_cycle();
      n++;
    end
    repeat (4) next_cycle();   // Late extra issues show up here
    foreach (test_tags[i]) begin
      assert (issue_cnt[test_tags[i]] == allowed[test_tags[i]]) else begin
        $display("** Error: issue_cnt[0x%h] = 0x%h, expected 0x%h",
                 test_tags[i], issue_cnt[test_tags[i]], allowed[test_tags[i]]);
        errors++;
      end
    end
    tests_run++;
    if (error_count() == err_start) $display("%s: ok", name);
    else begin
      tests_bad++;
      $display("%s: failed with %0d errors", name, error_count() - err_start);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_wakeup();
    inst_tag_t ta, tb, tc;
    rnid_t     ra0, ra1, rb;
    int        first;
    begin_test();
    ra0 = new_rnid();
    ra1 = new_rnid();
    rb  = new_rnid();
    ta  = alloc_tag();
    tb  = alloc_tag();
    tc  = alloc_tag();
    drive_put(ta, '0, 1'b1, ra0, 1'b1, ra1);
    next_cycle();
    drive_put(tb, '0, 1'b0, '0, 1'b1, rb);
    next_cycle();
    drive_put(tc, '0, 1'b0, '0, 1'b0, '0);   // No sources
    next_cycle();
    first = $urandom_range(2, 0);
    for (int k = 0; k < 3; k++) begin
      case ((first + k) % 3)
        0: drive_phy(ra0, 0);
        1: drive_early(ra1, 1'b0);
        default: drive_phy(rb, 1);
      endcase
      repeat (2) next_cycle();
    end
    end_test("wakeup");
  endtask

  task automatic test_replay();
    inst_tag_t ts, tn;
    rnid_t     rs, rn;
    begin_test();
    rs = new_rnid();
    rn = new_rnid();
    ts = alloc_tag();
    drive_put(ts, '0, 1'b1, rs, 1'b0, '0);
    next_cycle();
    drive_early(rs, 1'b1);
    next_cycle();
    assert (issue_cnt[ts] == 1) else begin
      $display("** Error: issue_cnt[0x%h] = 0x%h, expected 0x1", ts, issue_cnt[ts]);
      errors++;
    end
    drive_mispred(rs);
    allowed[ts] = 2;            // Replay after the miss
    repeat (3) next_cycle();
    drive_phy(rs, 1);
    next_cycle();
    tn = alloc_tag();
    drive_put(tn, '0, 1'b1, rn, 1'b0, '0);
    next_cycle();
    drive_early(rn, 1'b1);      // Load hits, no miss follows
    next_cycle();
    end_test("replay");
  endtask

  task automatic test_branch();
    inst_tag_t ta, tb, tc, td, te;
    rnid_t     r1, r2;
    begin_test();
    r1 = new_rnid();
    r2 = new_rnid();
    ta = alloc_tag();
    tb = alloc_tag();
    tc = alloc_tag();
    te = alloc_tag();
    drive_put(ta, 4'b0001, 1'b1, r1, 1'b0, '0);
    next_cycle();
    drive_put(tb, 4'b0000, 1'b1, r1, 1'b0, '0);
    next_cycle();
    drive_put(tc, 4'b0011, 1'b0, '0, 1'b1, r1);
    next_cycle();
    drive_put(te, 4'b0100, 1'b1, r2, 1'b0, '0);
    next_cycle();
    drive_br(2'd0, 1'b1);
    next_cycle();
    td = alloc_tag();
    drive_put(td, 4'b0010, 1'b0, '0, 1'b0, '0);
    drive_br(2'd1, 1'b1);       // Killed in its put cycle
    next_cycle();
    drive_br(2'd2, 1'b0);
    next_cycle();
    drive_phy(r2, 1);           // Op with bit 2 issues right after the update
    next_cycle();
    drive_phy(r1, 0);
    next_cycle();
    end_test("branch");
  endtask

  task automatic test_full();
    inst_tag_t t [4];
    rnid_t     r [4];
    inst_tag_t t5;
    int        cnt;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      r[i] = new_rnid();
      t[i] = alloc_tag();
      drive_put(t[i], '0, 1'b1, r[i], 1'b0, '0);
      next_cycle();
    end
    assert (full) else begin
      $display("** Error: o_full = 0x%h, expected 0x1", full);
      errors++;
    end
    drive_phy(r[0], 0);
    cnt = 0;
    next_cycle();
    while (full && cnt < 6) begin
      next_cycle();
      cnt++;
    end
    assert (cnt <= 2) else begin
      $display("o_full stayed high %0d cycles after issue", cnt + 1);
      errors++;
    end
    t5 = alloc_tag();
    drive_put(t5, '0, 1'b0, '0, 1'b0, '0);
    next_cycle();
    for (int i = 1; i < 4; i++) begin
      drive_phy(r[i], 0);
      next_cycle();
    end
    end_test("full");
  endtask

  task automatic test_port();
    inst_tag_t ta, tb, tc;
    rnid_t     r1, r2;
    begin_test();
    r1 = new_rnid();
    r2 = new_rnid();
    ta = alloc_tag();
    tb = alloc_tag();
    tc = alloc_tag();
    drive_put(ta, '0, 1'b1, r1, 1'b0, '0);
    next_cycle();
    drive_put(tb, '0, 1'b0, '0, 1'b1, r1);
    next_cycle();
    drive_put(tc, '0, 1'b1, r2, 1'b0, '0);
    next_cycle();
    drive_phy(r1, 0);           // Three ready in one cycle
    drive_early(r2, 1'b0);
    next_cycle();
    end_test("single port");
  endtask

  // --------------------
  // Main and watchdog
  // --------------------
  initial begin
    void'($urandom(9000));
    clear_bus();
    put_data   = '0;
    spec_now   = '0;
    rnid_ready = '0;
    used_rn    = '0;
    errors     = 0;
    tests_run  = 0;
    tests_bad  = 0;
    next_tag   = 8'h01;
    @(posedge reset_n);
    next_cycle();
    test_wakeup();
    test_replay();
    test_branch();
    test_full();
    test_port();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, error_count());
    if (error_count() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TOTAL_LEN * 2 * CLK_NS);
    $display("watchdog expired after %0d cycles", TOTAL_LEN * 2);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
common/sched_pkg.sv
common/bus_pkg.sv
issue/issue_entry.sv
issue/issue_picker.sv
issue/issue_alloc.sv
design/issue_sched_top.sv
dv/tb_clkgen.sv
dv/issue_sched_checker.sv
dv/issue_sched_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= issue_sched_tb
FILELIST  ?= build.f
PASS_MSG  := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
